// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = crg_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
design/crg_pkg.sv
design/pll_pkg.sv
design/rst_sequencer.sv
design/pll_preset_decode.sv
design/pll_cfg_select.sv
design/crg_top.sv
test/tb_clk_gen.sv
test/crg_chk.sv
test/crg_tb.sv

// File: design/crg_pkg.sv
`default_nettype none

package crg_pkg;

    // flops in each reset synchronizer
    localparam int SYNC_STAGES = 3;

    // reset extension counter width
    localparam int RST_CNT_W = 20;

    // clock select levels, one per PLL
    typedef struct packed {
        logic core;
        logic dev;
    } clk_sel_t;

endpackage

`default_nettype wire

// File: design/crg_top.sv
`default_nettype none

module crg_top
    import pll_pkg::*;
    import crg_pkg::*;
#(
    parameter logic [RST_CNT_W-1:0] RST_CNT_END = 20'd131071
) (
    input  logic          sys_clk,
    input  logic          rst_gen,
    input  logic          mode,
    input  pll_pins_t     pll_pins,
    input  pll_cfg_word_u soft_cfg_1,
    input  pll_cfg_word_u soft_cfg_2,
    input  logic          pll_cfg_ctr,
    input  pll_lock_t     pll_lock,
    output pll_settings_t pll1_settings,
    output pll_settings_t pll2_settings,
    output clk_sel_t      clk_sel,
    output logic          rst_core
);

    pll_settings_t hard1;
    pll_settings_t hard2;

    rst_sequencer #(
        .RST_CNT_END(RST_CNT_END)
    ) rst_sequencer_inst (
        .sys_clk (sys_clk),
        .rst_gen (rst_gen),
        .rst_core(rst_core)
    );

    pll_preset_decode pll_preset_decode_inst (
        .pll_pins(pll_pins),
        .hard1   (hard1),
        .hard2   (hard2)
    );

    pll_cfg_select pll_cfg_select_inst (
        .sys_clk      (sys_clk),
        .rst_gen      (rst_gen),
        .mode         (mode),
        .pll_cfg_ctr  (pll_cfg_ctr),
        .hard1        (hard1),
        .hard2        (hard2),
        .soft_cfg_1   (soft_cfg_1),
        .soft_cfg_2   (soft_cfg_2),
        .pll_lock     (pll_lock),
        .pll1_settings(pll1_settings),
        .pll2_settings(pll2_settings),
        .clk_sel      (clk_sel)
    );

endmodule

`default_nettype wire

// File: design/pll_cfg_select.sv
`default_nettype none

module pll_cfg_select
    import pll_pkg::*;
    import crg_pkg::*;
(
    input  logic          sys_clk,
    input  logic          rst_gen,
    input  logic          mode,
    input  logic          pll_cfg_ctr,
    input  pll_settings_t hard1,
    input  pll_settings_t hard2,
    input  pll_cfg_word_u soft_cfg_1,
    input  pll_cfg_word_u soft_cfg_2,
    input  pll_lock_t     pll_lock,
    output pll_settings_t pll1_settings,
    output pll_settings_t pll2_settings,
    output clk_sel_t      clk_sel
);

    pll_settings_t next1;
    pll_settings_t next2;
    clk_sel_t      next_sel;

    // hard mode wins, soft words only when software enables them
    always_comb begin
        next1 = hard1;
        next2 = hard2;
        if (!mode && pll_cfg_ctr) begin
            next1 = soft_cfg_1.fields.settings;
            next2 = soft_cfg_2.fields.settings;
        end
    end

    // each clock switches on its own lock
    assign next_sel.core = mode | (pll_cfg_ctr & pll_lock.pll1);
    assign next_sel.dev  = mode | (pll_cfg_ctr & pll_lock.pll2);

    always_ff @(posedge sys_clk or negedge rst_gen) begin
        if (!rst_gen) begin
            pll1_settings <= PLL_BYPASS_SETTINGS;
            pll2_settings <= PLL_BYPASS_SETTINGS;
            clk_sel       <= '0;
        end else begin
            pll1_settings <= next1;
            pll2_settings <= next2;
            clk_sel       <= next_sel;
        end
    end

endmodule

`default_nettype wire

// File: design/pll_pkg.sv
`default_nettype none

package pll_pkg;

    // settings for one PLL, bypass is bit 0
    typedef struct packed {
        logic [5:0]  refdiv;
        logic [2:0]  postdiv2;
        logic [2:0]  postdiv1;
        logic        pd;
        logic        reserved;
        logic        foutvcopd;
        logic        foutpostdivpd;
        logic [11:0] fbdiv;
        logic        dsmpd;
        logic        bypass;
    } pll_settings_t;

    typedef struct packed {
        logic [33:0]   unused;
        pll_settings_t settings;
    } pll_cfg_fields_t;

    // software settings word, raw or split into fields
    typedef union packed {
        logic [63:0]     raw;
        pll_cfg_fields_t fields;
    } pll_cfg_word_u;

    // configuration pins
    typedef struct packed {
        logic [1:0] pll2_code;
        logic [3:0] pll1_code;
    } pll_pins_t;

    typedef struct packed {
        logic pll1;
        logic pll2;
    } pll_lock_t;

    localparam pll_settings_t PLL_BYPASS_SETTINGS = '{
        refdiv: 6'd2, postdiv2: 3'd1, postdiv1: 3'd1, pd: 1'b0, reserved: 1'b0,
        foutvcopd: 1'b0, foutpostdivpd: 1'b0, fbdiv: 12'd20, dsmpd: 1'b1, bypass: 1'b1
    };

    // pll1 frequency presets share these
    localparam logic [5:0] PLL1_REFDIV   = 6'd2;
    localparam logic [2:0] PLL1_POSTDIV1 = 3'd2;

    localparam pll_settings_t PLL2_PRESET_A_SETTINGS = '{
        refdiv: 6'd4, postdiv2: 3'd1, postdiv1: 3'd5, pd: 1'b0, reserved: 1'b0,
        foutvcopd: 1'b0, foutpostdivpd: 1'b0, fbdiv: 12'd30, dsmpd: 1'b1, bypass: 1'b0
    };

    localparam pll_settings_t PLL2_PRESET_B_SETTINGS = '{
        refdiv: 6'd2, postdiv2: 3'd2, postdiv1: 3'd3, pd: 1'b0, reserved: 1'b0,
        foutvcopd: 1'b0, foutpostdivpd: 1'b0, fbdiv: 12'd24, dsmpd: 1'b1, bypass: 1'b0
    };

endpackage

`default_nettype wire

// File: design/pll_preset_decode.sv
`default_nettype none

module pll_preset_decode
    import pll_pkg::*;
(
    input  pll_pins_t     pll_pins,
    output pll_settings_t hard1,
    output pll_settings_t hard2
);

    // pll1 table
    // codes 1..8 step fbdiv by 4 from 20, everything else is bypass
    always_comb begin
        hard1 = PLL_BYPASS_SETTINGS;
        if (pll_pins.pll1_code >= 4'd1 && pll_pins.pll1_code <= 4'd8) begin
            hard1.bypass   = 1'b0;
            hard1.refdiv   = PLL1_REFDIV;
            hard1.postdiv1 = PLL1_POSTDIV1;
            hard1.fbdiv    = 12'd16 + {6'd0, pll_pins.pll1_code, 2'b00};
        end
    end

    // pll2 table
    always_comb begin
        case (pll_pins.pll2_code)
            2'd1: begin
                hard2 = PLL2_PRESET_A_SETTINGS;
            end
            2'd2: begin
                hard2 = PLL2_PRESET_B_SETTINGS;
            end
            default: begin
                hard2 = PLL_BYPASS_SETTINGS;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/rst_sequencer.sv
`default_nettype none

module rst_sequencer
    import crg_pkg::*;
#(
    parameter logic [RST_CNT_W-1:0] RST_CNT_END = 20'd131071
) (
    input  logic sys_clk,
    input  logic rst_gen,
    output logic rst_core
);

    logic [1:0]           sync_in_n;
    logic [1:0]           sync_out;
    logic [RST_CNT_W-1:0] rst_cnt;
    logic                 cnt_done;

    // stage 0 takes the pad reset, stage 1 the end of extension
    assign sync_in_n[0] = rst_gen;
    assign sync_in_n[1] = cnt_done;

    for (genvar i = 0; i < 2; i++) begin : g_sync
        logic [SYNC_STAGES-1:0] sync_q;

        always_ff @(posedge sys_clk or negedge sync_in_n[i]) begin
            if (!sync_in_n[i]) begin
                sync_q <= '0;
            end else begin
                sync_q <= {sync_q[SYNC_STAGES-2:0], 1'b1};
            end
        end

        assign sync_out[i] = sync_q[SYNC_STAGES-1];
    end

    // extension counter, saturates at the end count
    always_ff @(posedge sys_clk or negedge sync_out[0]) begin
        if (!sync_out[0]) begin
            rst_cnt <= '0;
        end else if (rst_cnt < RST_CNT_END) begin
            rst_cnt <= rst_cnt + 1'b1;
        end
    end

    assign cnt_done = (rst_cnt == RST_CNT_END);
    assign rst_core = sync_out[1];

endmodule

`default_nettype wire

// File: test/crg_chk.sv
`default_nettype none

module crg_chk
    import crg_pkg::*;
(
    input logic                 sys_clk,
    input logic                 rst_gen,
    input logic                 rst_core,
    input logic [RST_CNT_W-1:0] rst_cnt,
    input logic [RST_CNT_W-1:0] cnt_end,
    input clk_sel_t             clk_sel
);

    // core reset only drops together with the external reset
    rst_core_hold: assert property (
        @(posedge sys_clk) disable iff (!rst_gen) !$fell(rst_core)
    ) else $error("rst_core fell while rst_gen was high");

    // at least one synchronizer depth before core reset can release
    rst_core_delay: assert property (
        @(posedge sys_clk) disable iff (!rst_gen) $rose(rst_gen) |-> !rst_core [*SYNC_STAGES]
    ) else $error("rst_core released too early after rst_gen");

    sel_in_reset: assert property (
        @(posedge sys_clk) !rst_gen |-> clk_sel == 2'b00
    ) else $error("clk_sel not zero while rst_gen was low");

    cnt_bound: assert property (
        @(posedge sys_clk) disable iff (!rst_gen) rst_cnt <= cnt_end
    ) else $error("reset extension counter passed its end count");

endmodule

bind rst_sequencer crg_chk rst_chk_inst (
    .sys_clk (sys_clk),
    .rst_gen (rst_gen),
    .rst_core(rst_core),
    .rst_cnt (rst_cnt),
    .cnt_end (RST_CNT_END),
    .clk_sel (2'b00)
);

bind pll_cfg_select crg_chk sel_chk_inst (
    .sys_clk (sys_clk),
    .rst_gen (rst_gen),
    .rst_core(1'b0),
    .rst_cnt ('0),
    .cnt_end ('0),
    .clk_sel (clk_sel)
);

`default_nettype wire

// File: test/crg_tb.sv
`default_nettype none

module crg_tb
    import pll_pkg::*;
    import crg_pkg::*;
();

    localparam int RST_END      = 40;
    localparam int RST_CYCLES   = 8;
    localparam int SEQ_CYCLES   = RST_END + 10;
    localparam int N_SOFT       = 60;
    localparam int N_RAND       = 120;
    localparam int PULSE_CYCLES = 3;
    localparam int TEST_CYCLES  = 2 * SEQ_CYCLES + 65 + 2 * N_SOFT + N_RAND + PULSE_CYCLES + 2;
    localparam int TIMEOUT      = RST_CYCLES + TEST_CYCLES + 100;

    logic          sys_clk;
    logic          rst_gen;
    logic          rst_pulse;
    logic          mode;
    logic          pll_cfg_ctr;
    pll_pins_t     pll_pins;
    pll_cfg_word_u soft_cfg_1;
    pll_cfg_word_u soft_cfg_2;
    pll_lock_t     pll_lock;
    pll_settings_t pll1_settings;
    pll_settings_t pll2_settings;
    clk_sel_t      clk_sel;
    logic          rst_core;

    pll_settings_t exp_s1;
    pll_settings_t exp_s2;
    clk_sel_t      exp_sel;
    logic [15:0]   lfsr;
    int            rel_edges;
    int            cycle_cnt = 0;
    int            settings_errs;
    int            sel_errs;
    int            rst_errs;

    tb_clk_gen #(
        .HALF_PERIOD(10),
        .RST_CYCLES (RST_CYCLES)
    ) tb_clk_gen_inst (
        .rst_pulse(rst_pulse),
        .sys_clk  (sys_clk),
        .rst_gen  (rst_gen)
    );

    crg_top #(
        .RST_CNT_END(RST_CNT_W'(RST_END))
    ) crg_top_inst (
        .sys_clk      (sys_clk),
        .rst_gen      (rst_gen),
        .mode         (mode),
        .pll_pins     (pll_pins),
        .soft_cfg_1   (soft_cfg_1),
        .soft_cfg_2   (soft_cfg_2),
        .pll_cfg_ctr  (pll_cfg_ctr),
        .pll_lock     (pll_lock),
        .pll1_settings(pll1_settings),
        .pll2_settings(pll2_settings),
        .clk_sel      (clk_sel),
        .rst_core     (rst_core)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    function automatic pll_settings_t make_settings(input logic byp, input logic [5:0] refdiv,
            input logic [11:0] fbdiv, input logic [2:0] pd1, input logic [2:0] pd2);
        pll_settings_t s;
        s          = '0;
        s.bypass   = byp;
        s.dsmpd    = 1'b1;
        s.refdiv   = refdiv;
        s.fbdiv    = fbdiv;
        s.postdiv1 = pd1;
        s.postdiv2 = pd2;
        return s;
    endfunction

    function automatic pll_settings_t bypass_model();
        return make_settings(1'b1, 6'd2, 12'd20, 3'd1, 3'd1);
    endfunction

    function automatic pll_settings_t pll1_model(input logic [3:0] code);
        if (code >= 4'd1 && code <= 4'd8) begin
            return make_settings(1'b0, 6'd2, 12'(16 + 4 * int'(code)), 3'd2, 3'd1);
        end
        return bypass_model();
    endfunction

    function automatic pll_settings_t pll2_model(input logic [1:0] code);
        case (code)
            2'd1: return make_settings(1'b0, 6'd4, 12'd30, 3'd5, 3'd1);
            2'd2: return make_settings(1'b0, 6'd2, 12'd24, 3'd3, 3'd2);
            default: return bypass_model();
        endcase
    endfunction

    // what the outputs should hold after the next edge
    task automatic update_expected();
        if (mode) begin
            exp_s1 = pll1_model(pll_pins.pll1_code);
            exp_s2 = pll2_model(pll_pins.pll2_code);
        end else if (pll_cfg_ctr) begin
            exp_s1 = soft_cfg_1.fields.settings;
            exp_s2 = soft_cfg_2.fields.settings;
        end else begin
            exp_s1 = pll1_model(pll_pins.pll1_code);
            exp_s2 = pll2_model(pll_pins.pll2_code);
        end
        exp_sel.core = mode | (pll_cfg_ctr & pll_lock.pll1);
        exp_sel.dev  = mode | (pll_cfg_ctr & pll_lock.pll2);
    endtask

    task automatic drive(input logic m, input logic c, input pll_pins_t p);
        logic [63:0] bits;
        mode        = m;
        pll_cfg_ctr = c;
        pll_pins    = p;
        take_bits(64, bits);
        soft_cfg_1.raw = bits;
        take_bits(64, bits);
        soft_cfg_2.raw = bits;
        take_bits(2, bits);
        pll_lock = bits[1:0];
        update_expected();
    endtask

    task automatic check_settings(input string what, input pll_settings_t got,
            input pll_settings_t exp);
        if (got !== exp) begin
            settings_errs++;
            $display("Error at %0t: %s settings %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_clk_sel(input clk_sel_t got, input clk_sel_t exp);
        if (got !== exp) begin
            sel_errs++;
            $display("Error at %0t: clk_sel %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_rst(input logic got, input logic exp);
        if (got !== exp) begin
            rst_errs++;
            $display("Error at %0t: rst_core %b, expected %b (edge %0d after release)",
                $time, got, exp, rel_edges);
        end
    endtask

    // while in reset the selector holds bypass and deselected clocks
    task automatic check_outputs();
        if (rst_gen) begin
            check_settings("pll1", pll1_settings, exp_s1);
            check_settings("pll2", pll2_settings, exp_s2);
            check_clk_sel(clk_sel, exp_sel);
        end else begin
            check_settings("pll1", pll1_settings, bypass_model());
            check_settings("pll2", pll2_settings, bypass_model());
            check_clk_sel(clk_sel, 2'b00);
        end
        check_rst(rst_core, rst_gen && (rel_edges >= RST_END + 6));
    endtask

    task automatic step();
        @(posedge sys_clk);
        if (rst_gen) begin
            rel_edges++;
        end
        #1;
        check_outputs();
        #1;
    endtask

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        logic [63:0] bits;
        lfsr          = 16'd83;
        rst_pulse     = 1'b0;
        rel_edges     = 0;
        settings_errs = 0;
        sel_errs      = 0;
        rst_errs      = 0;
        drive(1'b0, 1'b0, '0);
        wait (rst_gen === 1'b1);

        // power-on reset sequence
        repeat (SEQ_CYCLES) step();

        // every pin code in hard mode
        for (int i = 0; i < 64; i++) begin
            take_bits(1, bits);
            drive(1'b1, bits[0], i[5:0]);
            step();
        end

        // soft words, then hard presets with software control off
        for (int i = 0; i < N_SOFT; i++) begin
            take_bits(6, bits);
            drive(1'b0, 1'b1, bits[5:0]);
            step();
        end
        for (int i = 0; i < N_SOFT; i++) begin
            take_bits(6, bits);
            drive(1'b0, 1'b0, bits[5:0]);
            step();
        end

        for (int i = 0; i < N_RAND; i++) begin
            take_bits(8, bits);
            drive(bits[7], bits[6], bits[5:0]);
            step();
        end

        // mid-run reset pulse
        rst_pulse = 1'b1;
        rel_edges = 0;
        #1;
        check_outputs();
        #1;
        repeat (PULSE_CYCLES) step();
        rst_pulse = 1'b0;
        repeat (SEQ_CYCLES) begin
            take_bits(8, bits);
            drive(bits[7], bits[6], bits[5:0]);
            step();
        end

        $display("errors: settings %0d, clk_sel %0d, rst_core %0d",
            settings_errs, sel_errs, rst_errs);
        if (settings_errs + sel_errs + rst_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RST_CYCLES  = 8
) (
    input  logic rst_pulse,
    output logic sys_clk,
    output logic rst_gen
);

    logic por_done;

    initial begin
        sys_clk = 1'b0;
        forever begin
            #HALF_PERIOD sys_clk = ~sys_clk;
        end
    end

    // power-on reset, released just after the last held edge
    initial begin
        por_done = 1'b0;
        repeat (RST_CYCLES) @(posedge sys_clk);
        #2 por_done = 1'b1;
    end

    assign rst_gen = por_done & ~rst_pulse;

endmodule

`default_nettype wire
